// File: Bender.yml
package:
  name: mipsExec

sources:
  - include_dirs:
      - .
    files:
      - mipsExecPkg.sv
      - mulDivIf.sv
      - intAlu.sv
      - mulDivUnit.sv
      - execResult.sv
      - mipsExec.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMipsExec.sv

// File: execResult.sv
`timescale 1ns/1ns

module execResult (
    input  logic                   clk,
    input  logic                   rstN,
    input  mipsExecPkg::aluCtrl_e   aluControl,
    input  mipsExecPkg::instrWord_u instr,
    input  mipsExecPkg::dataWord_t  srcA,
    input  mipsExecPkg::dataWord_t  aluResult,
    mulDivIf.sink                   md,
    output mipsExecPkg::dataWord_t  out,
    output logic                   stall
);
    import mipsExecPkg::*;

    logic       isRType;
    functCode_e funct;
    dataWord_t  hiReg;
    dataWord_t  loReg;

    assign isRType = (aluControl == aluRType);
    assign funct   = instr.r.funct;

    // a running multiply/divide holds the pipeline
    assign stall = md.busy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiReg <= '0;
            loReg <= '0;
        end else if (md.done) begin
            hiReg <= md.hi;
            loReg <= md.lo;
        end else if (isRType) begin
            if (funct == fnMthi) begin
                hiReg <= srcA;
            end
            if (funct == fnMtlo) begin
                loReg <= srcA;
            end
        end
    end

    always_comb begin
        out = aluResult;
        if (md.busy || md.done) begin
            // nothing to write back from a multiply/divide
            out = '0;
        end else if (isRType) begin
            case (funct)
                fnMfhi:         out = hiReg;
                fnMflo:         out = loReg;
                fnMthi, fnMtlo: out = '0;
                default:        out = aluResult;
            endcase
        end
    end

endmodule

// File: intAlu.sv
`timescale 1ns/1ns
`include "mipsExec_consts.svh"

module intAlu (
    input  mipsExecPkg::aluCtrl_e   aluControl,
    input  mipsExecPkg::instrWord_u instr,
    input  mipsExecPkg::dataWord_t  srcA,
    input  mipsExecPkg::dataWord_t  srcB,
    output mipsExecPkg::dataWord_t  aluResult
);
    import mipsExecPkg::*;

    localparam int HalfWidth = `DATA_WIDTH / 2;

    logic                    isRType;
    functCode_e              funct;
    aluCtrl_e                op;
    dataWord_t               opA;
    logic [`SHAMT_WIDTH-1:0] shiftAmt;

    assign isRType  = (aluControl == aluRType);
    assign funct    = instr.r.funct;
    assign shiftAmt = opA[`SHAMT_WIDTH-1:0];

    // funct to ALU operation, anything unknown falls to aluRType
    always_comb begin
        op = aluControl;
        if (isRType) begin
            case (funct)
                fnSll, fnSllv: op = aluSll;
                fnSrl, fnSrlv: op = aluSrl;
                fnSra, fnSrav: op = aluSra;
                fnAddu:        op = aluAdd;
                fnSubu:        op = aluSub;
                fnAnd:         op = aluAnd;
                fnOr:          op = aluOr;
                fnXor:         op = aluXor;
                fnSlt:         op = aluSlt;
                fnSltu:        op = aluSltu;
                default:       op = aluRType;
            endcase
        end
    end

    // operand A select
    always_comb begin
        opA = srcA;
        if (aluControl == aluLui) begin
            opA = {{(`DATA_WIDTH - 16){1'b0}}, instr.i.imm};
        end else if (isRType) begin
            case (funct)
                fnSll, fnSrl, fnSra: begin
                    opA = {{(`DATA_WIDTH - `SHAMT_WIDTH){1'b0}}, instr.r.shamt};
                end
                fnSllv, fnSrlv, fnSrav: begin
                    opA = {{(`DATA_WIDTH - `SHAMT_WIDTH){1'b0}}, srcA[`SHAMT_WIDTH-1:0]};
                end
                default: opA = srcA;
            endcase
        end
    end

    always_comb begin
        case (op)
            aluAnd:  aluResult = opA & srcB;
            aluOr:   aluResult = opA | srcB;
            aluXor:  aluResult = opA ^ srcB;
            aluAdd:  aluResult = opA + srcB;
            aluSub:  aluResult = opA - srcB;
            // shifts always move srcB
            aluSll:  aluResult = srcB << shiftAmt;
            aluSrl:  aluResult = srcB >> shiftAmt;
            aluSra:  aluResult = dataWord_t'($signed(srcB) >>> shiftAmt);
            aluSlt:  aluResult = {{(`DATA_WIDTH - 1){1'b0}}, $signed(opA) < $signed(srcB)};
            aluSltu: aluResult = {{(`DATA_WIDTH - 1){1'b0}}, opA < srcB};
            aluLui:  aluResult = {opA[HalfWidth-1:0], {HalfWidth{1'b0}}};
            default: aluResult = '0;
        endcase
    end

endmodule

// File: mipsExec.f
+incdir+.
mipsExecPkg.sv
mulDivIf.sv
intAlu.sv
mulDivUnit.sv
execResult.sv
mipsExec.sv
tbMipsExec.sv

// File: mipsExec.sv
`timescale 1ns/1ns

module mipsExec (
    input  logic                   clk,
    input  logic                   rstN,
    input  mipsExecPkg::aluCtrl_e   aluControl,
    input  mipsExecPkg::instrWord_u instr,
    input  mipsExecPkg::dataWord_t  srcA,
    input  mipsExecPkg::dataWord_t  srcB,
    output mipsExecPkg::dataWord_t  out,
    output logic                   stall
);
    import mipsExecPkg::*;

    dataWord_t aluResult;

    mulDivIf md ();

    // single-cycle ALU path
    intAlu uAlu (
        .aluControl (aluControl),
        .instr      (instr),
        .srcA       (srcA),
        .srcB       (srcB),
        .aluResult  (aluResult)
    );

    // multi-cycle path, runs beside the ALU
    mulDivUnit uMulDiv (
        .clk        (clk),
        .rstN       (rstN),
        .aluControl (aluControl),
        .instr      (instr),
        .srcA       (srcA),
        .srcB       (srcB),
        .md         (md.unit)
    );

    execResult uResult (
        .clk        (clk),
        .rstN       (rstN),
        .aluControl (aluControl),
        .instr      (instr),
        .srcA       (srcA),
        .aluResult  (aluResult),
        .md         (md.sink),
        .out        (out),
        .stall      (stall)
    );

endmodule

// File: mipsExecPkg.sv
`include "mipsExec_consts.svh"

package mipsExecPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWord_t;

    // ALU control from the decoder, rType means look at funct
    typedef enum logic [4:0] {
        aluAnd   = 5'b00000,
        aluOr    = 5'b00001,
        aluAdd   = 5'b00010,
        aluXor   = 5'b00011,
        aluSll   = 5'b00100,
        aluSrl   = 5'b00101,
        aluSub   = 5'b00110,
        aluSlt   = 5'b00111,
        aluSra   = 5'b01000,
        aluSltu  = 5'b01001,
        aluRType = 5'b01111,
        aluLui   = 5'b10001
    } aluCtrl_e;

    typedef enum logic [5:0] {
        fnSll   = 6'b000000,
        fnSrl   = 6'b000010,
        fnSra   = 6'b000011,
        fnSllv  = 6'b000100,
        fnSrlv  = 6'b000110,
        fnSrav  = 6'b000111,
        fnMfhi  = 6'b010000,
        fnMthi  = 6'b010001,
        fnMflo  = 6'b010010,
        fnMtlo  = 6'b010011,
        fnMult  = 6'b011000,
        fnMultu = 6'b011001,
        fnDiv   = 6'b011010,
        fnDivu  = 6'b011011,
        fnAddu  = 6'b100001,
        fnSubu  = 6'b100011,
        fnAnd   = 6'b100100,
        fnOr    = 6'b100101,
        fnXor   = 6'b100110,
        fnSlt   = 6'b101010,
        fnSltu  = 6'b101011
    } functCode_e;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [4:0]              rs;
        logic [4:0]              rt;
        logic [4:0]              rd;
        logic [`SHAMT_WIDTH-1:0] shamt;
        functCode_e              funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields_t;

    // same instruction word, R-type view for funct/shamt, I-type view for LUI
    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instrWord_u;

endpackage

// File: mipsExec_consts.svh
`ifndef MIPS_EXEC_CONSTS_SVH
`define MIPS_EXEC_CONSTS_SVH

// datapath word size
`define DATA_WIDTH 32

// shamt field of an R-type instruction
// also the number of low srcA bits used by the variable shifts
`define SHAMT_WIDTH 5

// cycles from request to done for MULT/MULTU/DIV/DIVU
// one load cycle followed by one iteration step per data bit
`define MULDIV_CYCLES 33

// width of the multiply/divide cycle counter
// must hold MULDIV_CYCLES - 1
`define MULDIV_CNT_WIDTH 6

`endif

// File: mulDivIf.sv
`timescale 1ns/1ns

interface mulDivIf;
    import mipsExecPkg::*;

    // one-cycle pulse, hi/lo valid with it
    logic done;
    // request present and not yet done
    logic busy;
    dataWord_t hi;
    dataWord_t lo;

    modport unit (
        output done,
        output busy,
        output hi,
        output lo
    );

    modport sink (
        input done,
        input busy,
        input hi,
        input lo
    );

endinterface

// File: mulDivUnit.sv
`timescale 1ns/1ns
`include "mipsExec_consts.svh"

module mulDivUnit (
    input logic                   clk,
    input logic                   rstN,
    input mipsExecPkg::aluCtrl_e   aluControl,
    input mipsExecPkg::instrWord_u instr,
    input mipsExecPkg::dataWord_t  srcA,
    input mipsExecPkg::dataWord_t  srcB,
    mulDivIf.unit                  md
);
    import mipsExecPkg::*;

    localparam int Msb = `DATA_WIDTH - 1;
    localparam logic [`MULDIV_CNT_WIDTH-1:0] LastCnt =
        `MULDIV_CNT_WIDTH'(`MULDIV_CYCLES - 1);

    logic                         req;
    logic                         reqDiv;
    logic                         reqSigned;
    logic                         running;
    logic [`MULDIV_CNT_WIDTH-1:0] cnt;
    logic                         isDiv;
    logic                         negHi;
    logic                         negLo;
    dataWord_t                    accHi;
    dataWord_t                    accLo;
    dataWord_t                    opM;
    dataWord_t                    magA;
    dataWord_t                    magB;
    dataWord_t                    stepHi;
    dataWord_t                    stepLo;
    logic [`DATA_WIDTH:0]         addSum;
    logic [`DATA_WIDTH:0]         divShift;
    logic [`DATA_WIDTH:0]         divDiff;
    logic                         divFits;
    logic [2*`DATA_WIDTH-1:0]     prodFix;

    always_comb begin
        req       = 1'b0;
        reqDiv    = 1'b0;
        reqSigned = 1'b0;
        if (aluControl == aluRType) begin
            case (instr.r.funct)
                fnMult:  {req, reqDiv, reqSigned} = 3'b101;
                fnMultu: {req, reqDiv, reqSigned} = 3'b100;
                fnDiv:   {req, reqDiv, reqSigned} = 3'b111;
                fnDivu:  {req, reqDiv, reqSigned} = 3'b110;
                default: {req, reqDiv, reqSigned} = 3'b000;
            endcase
        end
    end

    // iterate on magnitudes, sign is put back at the end
    assign magA = (reqSigned && srcA[Msb]) ? -srcA : srcA;
    assign magB = (reqSigned && srcB[Msb]) ? -srcB : srcB;

    assign md.done = running && (cnt == LastCnt);
    assign md.busy = req && !md.done;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (!running) begin
            if (req) begin
                running <= 1'b1;
                cnt     <= `MULDIV_CNT_WIDTH'(1);
            end
        end else if (md.done) begin
            running <= 1'b0;
            cnt     <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // load while idle, step while running
    always_ff @(posedge clk) begin
        if (!running) begin
            isDiv <= reqDiv;
            negLo <= reqSigned && (srcA[Msb] ^ srcB[Msb]);
            negHi <= reqSigned && srcA[Msb];
            opM   <= magB;
            accHi <= '0;
            accLo <= magA;
        end else begin
            accHi <= stepHi;
            accLo <= stepLo;
        end
    end

    // one shift-add or restoring-divide step
    // last step is only seen combinationally in the done cycle
    always_comb begin
        addSum   = {1'b0, accHi} + (accLo[0] ? {1'b0, opM} : '0);
        divShift = {accHi, accLo[Msb]};
        divDiff  = divShift - {1'b0, opM};
        divFits  = (divShift >= {1'b0, opM});
        if (isDiv) begin
            stepHi = divFits ? divDiff[Msb:0] : divShift[Msb:0];
            stepLo = {accLo[Msb-1:0], divFits};
        end else begin
            stepHi = addSum[`DATA_WIDTH:1];
            stepLo = {addSum[0], accLo[Msb:1]};
        end
    end

    // remainder follows the dividend sign
    always_comb begin
        prodFix = negLo ? -{stepHi, stepLo} : {stepHi, stepLo};
        if (isDiv) begin
            md.hi = negHi ? -stepHi : stepHi;
            md.lo = negLo ? -stepLo : stepLo;
        end else begin
            md.hi = prodFix[2*`DATA_WIDTH-1:`DATA_WIDTH];
            md.lo = prodFix[Msb:0];
        end
    end

endmodule

// File: tbMipsExec.sv
`timescale 1ns/1ns
`include "mipsExec_consts.svh"

module tbMipsExec;
    import mipsExecPkg::*;

    localparam int StallLimit = 40;

    logic       clk;
    logic       rstN;
    aluCtrl_e   aluControl;
    instrWord_u instr;
    dataWord_t  srcA;
    dataWord_t  srcB;
    dataWord_t  out;
    logic       stall;

    // expected contents of the Hi/Lo registers
    dataWord_t   hiModel;
    dataWord_t   loModel;
    logic [31:0] lcgState;

    aluCtrl_e immOps [11] = '{aluAnd, aluOr, aluAdd, aluXor, aluSll, aluSrl, aluSub,
                              aluSlt, aluSra, aluSltu, aluLui};
    // arithmetic and logic first, shifts after
    functCode_e aluFns [13] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu,
                                fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};
    functCode_e mdFns [4] = '{fnMult, fnMultu, fnDiv, fnDivu};
    dataWord_t cornerVals [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0};

    mipsExec mipsExec_inst (
        .clk        (clk),
        .rstN       (rstN),
        .aluControl (aluControl),
        .instr      (instr),
        .srcA       (srcA),
        .srcB       (srcB),
        .out        (out),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // random R-type word with the given funct, shamt stays random
    function automatic instrWord_u makeR(functCode_e fn);
        instrWord_u w;
        w = nextRand();
        w.r.funct = fn;
        return w;
    endfunction

    // nonzero, and never -1 so a signed divide cannot overflow
    function automatic dataWord_t randDivisor();
        dataWord_t d;
        d = nextRand();
        if (d == '0 || d == '1) begin
            d = 32'd7;
        end
        return d;
    endfunction

    function automatic logic isMulDiv(aluCtrl_e ctrl, functCode_e fn);
        if (ctrl != aluRType) begin
            return 1'b0;
        end
        case (fn)
            fnMult, fnMultu, fnDiv, fnDivu: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic dataWord_t refOut(aluCtrl_e ctrl, instrWord_u ins,
                                         dataWord_t a, dataWord_t b);
        logic [4:0] sh;
        logic [4:0] va;
        sh = ins.r.shamt;
        va = a[4:0];
        if (ctrl == aluRType) begin
            case (ins.r.funct)
                fnSll:  return b << sh;
                fnSrl:  return b >> sh;
                fnSra:  return $signed(b) >>> sh;
                fnSllv: return b << va;
                fnSrlv: return b >> va;
                fnSrav: return $signed(b) >>> va;
                fnAddu: return a + b;
                fnSubu: return a - b;
                fnAnd:  return a & b;
                fnOr:   return a | b;
                fnXor:  return a ^ b;
                fnSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fnSltu: return (a < b) ? 32'd1 : 32'd0;
                fnMfhi: return hiModel;
                fnMflo: return loModel;
                default: return '0;
            endcase
        end
        case (ctrl)
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluAdd:  return a + b;
            aluXor:  return a ^ b;
            aluSll:  return b << va;
            aluSrl:  return b >> va;
            aluSub:  return a - b;
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSra:  return $signed(b) >>> va;
            aluSltu: return (a < b) ? 32'd1 : 32'd0;
            aluLui:  return {ins.i.imm, 16'h0000};
            default: return '0;
        endcase
    endfunction

    // {hi, lo} after a multiply or divide
    function automatic logic [63:0] refMulDiv(functCode_e fn, dataWord_t a, dataWord_t b);
        int sa;
        int sb;
        sa = a;
        sb = b;
        case (fn)
            fnMult:  return longint'(sa) * longint'(sb);
            fnMultu: return {32'b0, a} * {32'b0, b};
            fnDiv:   return {dataWord_t'(sa % sb), dataWord_t'(sa / sb)};
            fnDivu:  return {a % b, a / b};
            default: return '0;
        endcase
    endfunction

    task automatic checkWord(dataWord_t got, dataWord_t exp, string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("Simulation failed");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic checkStall(logic got, logic exp, string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp);
            $display("Simulation failed");
            $fatal(1, "stall compare failed");
        end
    endtask

    // drive one instruction, check it, and hold it until the stall clears
    task automatic applyOp(aluCtrl_e ctrl, instrWord_u ins, dataWord_t a, dataWord_t b);
        logic        md;
        logic        waiting;
        int          cycles;
        logic [63:0] hiLo;
        md = isMulDiv(ctrl, ins.r.funct);
        @(posedge clk);
        aluControl <= ctrl;
        instr      <= ins;
        srcA       <= a;
        srcB       <= b;
        @(negedge clk);
        checkWord(out, refOut(ctrl, ins, a, b), "out");
        checkStall(stall, md, "stall in first cycle");
        if (md) begin
            cycles  = 1;
            waiting = 1'b1;
            while (waiting) begin
                @(negedge clk);
                if (!stall) begin
                    waiting = 1'b0;
                end else begin
                    cycles++;
                    if (cycles > StallLimit) begin
                        $display("ERROR at %0t: stall never fell within %0d cycles",
                                 $time, StallLimit);
                        $display("Simulation failed");
                        $fatal(1, "stall timeout");
                    end
                end
            end
            checkWord(dataWord_t'(cycles), dataWord_t'(`MULDIV_CYCLES - 1), "stall cycles");
            hiLo    = refMulDiv(ins.r.funct, a, b);
            hiModel = hiLo[63:32];
            loModel = hiLo[31:0];
        end else if (ctrl == aluRType && ins.r.funct == fnMthi) begin
            hiModel = a;
        end else if (ctrl == aluRType && ins.r.funct == fnMtlo) begin
            loModel = a;
        end
    endtask

    task automatic readHiLo();
        applyOp(aluRType, makeR(fnMfhi), nextRand(), nextRand());
        applyOp(aluRType, makeR(fnMflo), nextRand(), nextRand());
    endtask

    initial begin
        lcgState   = 32'd8828;
        hiModel    = '0;
        loModel    = '0;
        rstN       = 1'b0;
        aluControl = aluAnd;
        instr      = '0;
        srcA       = '0;
        srcB       = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        // Hi/Lo read back as zero out of reset
        readHiLo();

        repeat (4) begin
            foreach (immOps[k]) begin
                applyOp(immOps[k], nextRand(), nextRand(), nextRand());
            end
            foreach (aluFns[k]) begin
                applyOp(aluRType, makeR(aluFns[k]), nextRand(), nextRand());
            end
        end

        // signed extremes and equal operands
        for (int k = 0; k < 7; k++) begin
            foreach (cornerVals[i]) begin
                foreach (cornerVals[j]) begin
                    applyOp(aluRType, makeR(aluFns[k]), cornerVals[i], cornerVals[j]);
                end
            end
        end

        applyOp(aluRType, makeR(fnMtlo), nextRand(), nextRand());
        applyOp(aluRType, makeR(fnMthi), nextRand(), nextRand());
        readHiLo();
        applyOp(aluRType, makeR(fnMthi), nextRand(), nextRand());
        readHiLo();
        applyOp(aluRType, makeR(fnMtlo), nextRand(), nextRand());
        readHiLo();

        repeat (3) begin
            foreach (mdFns[k]) begin
                applyOp(aluRType, makeR(mdFns[k]), nextRand(), randDivisor());
                readHiLo();
            end
        end
        applyOp(aluRType, makeR(fnDiv), -32'sd7, 32'd2);
        readHiLo();
        applyOp(aluRType, makeR(fnMult), -32'sd3, 32'd5);
        readHiLo();

        // second operation starts right in the cycle after the first one's done
        applyOp(aluRType, makeR(fnMult), nextRand(), nextRand());
        applyOp(aluRType, makeR(fnDivu), nextRand(), randDivisor());
        readHiLo();
        applyOp(aluRType, makeR(fnDiv), nextRand(), randDivisor());
        applyOp(aluRType, makeR(fnMultu), nextRand(), nextRand());
        readHiLo();

        $display("Simulation passed");
        $finish;
    end

endmodule
